//--- common/uart_pkg.sv
package uart_pkg;

    // line timing and frame shape
    localparam int clks_per_bit = 8;    // any value of 2 or more works
    localparam int data_bits    = 8;
    localparam int err_cnt_w    = 8;

    // derived widths
    localparam int half_bit   = clks_per_bit / 2;
    localparam int baud_cnt_w = (clks_per_bit > 2) ? $clog2(clks_per_bit) : 1;
    localparam int bit_idx_w  = (data_bits > 2) ? $clog2(data_bits) : 1;

    // engines treat the unnamed value 3 as none
    typedef enum logic [1:0] {
        parity_none = 2'd0,
        parity_odd  = 2'd1,
        parity_even = 2'd2
    } parity_t;

    // host register map
    typedef enum logic [1:0] {
        addr_ctrl     = 2'd0,   // parity mode in bits 1:0
        addr_perr_cnt = 2'd1,   // write clears
        addr_ferr_cnt = 2'd2    // write clears
    } reg_addr_t;

    typedef enum logic [2:0] {
        txs_idle, txs_start, txs_data, txs_parity, txs_stop
    } tx_state_t;

    typedef enum logic [2:0] {
        rxs_idle, rxs_start, rxs_data, rxs_parity, rxs_stop
    } rx_state_t;

endpackage

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [data_bits-1:0] tx_data,
    input  logic                 tx_valid,
    input  parity_t              parity_mode,
    output logic                 tx_ready,
    output logic                 uart_out
);

    tx_state_t             state;
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [bit_idx_w-1:0]  bit_idx;
    logic [data_bits-1:0]  shreg;      // bit 0 is the one on the line
    logic                  par_en;     // mode latched at acceptance
    logic                  par_bit;
    logic                  bit_done;

    assign bit_done = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));

    // line changes on the same edge as the state, so every bit is
    // exactly clks_per_bit cycles and the output never glitches
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= txs_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            shreg    <= '0;
            par_en   <= 1'b0;
            par_bit  <= 1'b0;
            tx_ready <= 1'b1;
            uart_out <= 1'b1;
        end else begin
            if (state == txs_idle || bit_done)
                baud_cnt <= '0;
            else
                baud_cnt <= baud_cnt + 1'b1;

            case (state)
                txs_idle: begin
                    if (tx_valid && tx_ready) begin
                        shreg    <= tx_data;
                        par_en   <= (parity_mode == parity_odd) ||
                                    (parity_mode == parity_even);
                        // odd mode inverts the data xor
                        par_bit  <= (parity_mode == parity_odd) ? ~(^tx_data) : ^tx_data;
                        bit_idx  <= '0;
                        tx_ready <= 1'b0;
                        uart_out <= 1'b0;   // start bit
                        state    <= txs_start;
                    end
                end
                txs_start: begin
                    if (bit_done) begin
                        uart_out <= shreg[0];
                        state    <= txs_data;
                    end
                end
                txs_data: begin
                    if (bit_done) begin
                        if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                            if (par_en) begin
                                uart_out <= par_bit;
                                state    <= txs_parity;
                            end else begin
                                uart_out <= 1'b1;   // straight to stop without parity
                                state    <= txs_stop;
                            end
                        end else begin
                            shreg    <= {1'b0, shreg[data_bits-1:1]};
                            uart_out <= shreg[1];   // next bit, LSB first
                            bit_idx  <= bit_idx + 1'b1;
                        end
                    end
                end
                txs_parity: begin
                    if (bit_done) begin
                        uart_out <= 1'b1;
                        state    <= txs_stop;
                    end
                end
                txs_stop: begin
                    if (bit_done) begin
                        tx_ready <= 1'b1;   // line already high
                        state    <= txs_idle;
                    end
                end
                default: begin
                    uart_out <= 1'b1;
                    tx_ready <= 1'b1;
                    state    <= txs_idle;
                end
            endcase
        end
    end

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 uart_in,
    input  parity_t              parity_mode,
    output logic [data_bits-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 perr_pulse,
    output logic                 ferr_pulse
);

    rx_state_t             state;
    logic [1:0]            sync;       // two-flop synchronizer
    logic                  line;
    logic                  line_q;     // previous line value, for edge detect
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [bit_idx_w-1:0]  bit_idx;
    logic [data_bits-1:0]  shreg;
    logic                  par_en;
    logic                  par_odd;
    logic                  par_rx;     // received parity bit
    logic                  par_err;
    logic                  bit_done;
    logic                  half_done;
    logic                  cnt_clr;

    assign line      = sync[1];
    assign bit_done  = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));
    assign half_done = (baud_cnt == baud_cnt_w'(half_bit - 1));
    assign cnt_clr   = (state == rxs_idle) || bit_done ||
                       (state == rxs_start && half_done);

    // zero when the ones in data plus parity bit match the mode
    assign par_err = par_en & (^shreg ^ par_rx ^ par_odd);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync       <= 2'b11;
            line_q     <= 1'b1;
            state      <= rxs_idle;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            shreg      <= '0;
            par_en     <= 1'b0;
            par_odd    <= 1'b0;
            par_rx     <= 1'b0;
            rx_data    <= '0;
            rx_valid   <= 1'b0;
            perr_pulse <= 1'b0;
            ferr_pulse <= 1'b0;
        end else begin
            sync       <= {sync[0], uart_in};
            line_q     <= line;
            rx_valid   <= 1'b0;
            perr_pulse <= 1'b0;
            ferr_pulse <= 1'b0;
            baud_cnt   <= cnt_clr ? '0 : baud_cnt + 1'b1;

            case (state)
                rxs_idle: begin
                    if (line_q && !line)
                        state <= rxs_start;     // falling edge
                end
                rxs_start: begin
                    if (half_done) begin
                        if (line) begin
                            state <= rxs_idle;  // glitch, not a start bit
                        end else begin
                            par_en  <= (parity_mode == parity_odd) ||
                                       (parity_mode == parity_even);
                            par_odd <= (parity_mode == parity_odd);
                            bit_idx <= '0;
                            state   <= rxs_data;
                        end
                    end
                end
                rxs_data: begin
                    if (bit_done) begin
                        shreg <= {line, shreg[data_bits-1:1]};   // LSB arrives first
                        if (bit_idx == bit_idx_w'(data_bits - 1))
                            state <= par_en ? rxs_parity : rxs_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                rxs_parity: begin
                    if (bit_done) begin
                        par_rx <= line;
                        state  <= rxs_stop;
                    end
                end
                rxs_stop: begin
                    if (bit_done) begin
                        state <= rxs_idle;
                        // framing error wins over parity
                        if (!line) begin
                            ferr_pulse <= 1'b1;
                        end else if (par_err) begin
                            perr_pulse <= 1'b1;
                        end else begin
                            rx_data  <= shreg;
                            rx_valid <= 1'b1;
                        end
                    end
                end
                default: state <= rxs_idle;
            endcase
        end
    end

endmodule

//--- rtl/uart_regs.sv
`timescale 1ns/1ns

module uart_regs import uart_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      host_req,
    input  logic      host_we,
    input  reg_addr_t host_addr,
    input  logic [7:0] host_wdata,
    output logic      host_ack,
    output logic [7:0] host_rdata,
    input  logic      perr_pulse,
    input  logic      ferr_pulse,
    output parity_t   parity_mode
);

    logic [err_cnt_w-1:0] perr_cnt;
    logic [err_cnt_w-1:0] ferr_cnt;
    logic                 access;     // first cycle of a request
    logic                 perr_clr;
    logic                 ferr_clr;

    // saturating counter step where a clear beats a pulse in the same cycle
    function automatic logic [err_cnt_w-1:0] cnt_next(
        input logic [err_cnt_w-1:0] cnt,
        input logic                 clr,
        input logic                 inc
    );
        if (clr)
            return '0;
        else if (inc && cnt != '1)
            return cnt + 1'b1;
        else
            return cnt;
    endfunction

    assign access   = host_req && !host_ack;
    assign perr_clr = access && host_we && (host_addr == addr_perr_cnt);
    assign ferr_clr = access && host_we && (host_addr == addr_ferr_cnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            host_ack    <= 1'b0;
            host_rdata  <= '0;
            parity_mode <= parity_none;
            perr_cnt    <= '0;
            ferr_cnt    <= '0;
        end else begin
            host_ack <= host_req;   // rises and falls one cycle behind req
            perr_cnt <= cnt_next(perr_cnt, perr_clr, perr_pulse);
            ferr_cnt <= cnt_next(ferr_cnt, ferr_clr, ferr_pulse);

            if (access && host_we && host_addr == addr_ctrl)
                parity_mode <= parity_t'(host_wdata[1:0]);

            if (access && !host_we) begin
                case (host_addr)
                    addr_ctrl:     host_rdata <= {6'd0, parity_mode};
                    addr_perr_cnt: host_rdata <= 8'(perr_cnt);
                    addr_ferr_cnt: host_rdata <= 8'(ferr_cnt);
                    default:       host_rdata <= '0;   // unmapped
                endcase
            end
        end
    end

endmodule

//--- rtl/uart_core.sv
`timescale 1ns/1ns

module uart_core import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [data_bits-1:0] tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 uart_out,
    input  logic                 uart_in,
    output logic [data_bits-1:0] rx_data,
    output logic                 rx_valid,
    input  logic                 host_req,
    input  logic                 host_we,
    input  reg_addr_t            host_addr,
    input  logic [7:0]           host_wdata,
    output logic                 host_ack,
    output logic [7:0]           host_rdata
);

    parity_t parity_mode;   // from regs to both engines
    logic    perr_pulse;
    logic    ferr_pulse;

    uart_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_ack    (host_ack),
        .host_rdata  (host_rdata),
        .perr_pulse  (perr_pulse),
        .ferr_pulse  (ferr_pulse),
        .parity_mode (parity_mode)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .parity_mode (parity_mode),
        .tx_ready    (tx_ready),
        .uart_out    (uart_out)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .uart_in     (uart_in),
        .parity_mode (parity_mode),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .perr_pulse  (perr_pulse),
        .ferr_pulse  (ferr_pulse)
    );

endmodule

//--- testbench/uart_core_assert.sv
`timescale 1ns/1ns

module uart_core_assert import uart_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      tx_ready,
    input logic      uart_out,
    input logic      host_req,
    input logic      host_ack,
    input logic      rx_valid,
    input logic      perr_pulse,
    input logic      ferr_pulse,
    input tx_state_t tx_state
);

    int low_cnt;   // cycles with tx_ready low

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            low_cnt <= 0;
        else
            low_cnt <= tx_ready ? 0 : low_cnt + 1;
    end

    // a frame is 10 bits, or 11 with parity
    a_frame_len: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_ready) |-> (low_cnt == 10 * clks_per_bit || low_cnt == 11 * clks_per_bit))
        else $error("tx_ready was low for %0d cycles, not one frame", low_cnt);

    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        host_req && !host_ack |=> host_ack)
        else $error("host_ack did not rise one cycle after host_req");

    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        !host_req && host_ack |=> !host_ack)
        else $error("host_ack did not fall one cycle after host_req dropped");

    a_new_req: assert property (@(posedge clk) disable iff (rst)
        $rose(host_req) |-> !host_ack)
        else $error("new host request while host_ack still high");

    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rx_valid, perr_pulse, ferr_pulse}))
        else $error("more than one receive outcome in one cycle");

    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        tx_state == txs_idle |-> uart_out)
        else $error("uart_out low while the transmitter is idle");

endmodule

bind uart_core uart_core_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .tx_ready   (tx_ready),
    .uart_out   (uart_out),
    .host_req   (host_req),
    .host_ack   (host_ack),
    .rx_valid   (rx_valid),
    .perr_pulse (perr_pulse),
    .ferr_pulse (ferr_pulse),
    .tx_state   (u_tx.state)
);

//--- testbench/tb_uart_core.sv
`timescale 1ns/1ns

module tb_uart_core import uart_pkg::*; ();

    typedef enum logic [1:0] {inj_none, inj_flip_parity, inj_stop_low} inj_t;
    typedef enum logic [1:0] {exp_ok, exp_perr, exp_ferr} outcome_t;
    typedef struct packed {
        parity_t    mode;
        logic [7:0] data;
        logic       rnd;    // data comes from the xorshift stream
        inj_t       inj;
        outcome_t   exp;
    } entry_t;

    localparam int n_entries  = 10;
    // table plus reset and back-pressure runs, two frame times each, plus host traffic
    localparam int max_cycles = (n_entries + 4) * 11 * clks_per_bit * 2 + 400;

    logic                 clk;
    logic                 rst;
    logic [data_bits-1:0] tx_data;
    logic [data_bits-1:0] rx_data;
    logic                 tx_valid, tx_ready, uart_out, uart_in, rx_valid;
    logic                 host_req, host_we, host_ack;
    reg_addr_t            host_addr;
    logic [7:0]           host_wdata, host_rdata;
    logic                 bang;              // forces a frame onto uart_in
    logic                 bang_bit;
    entry_t               tests [n_entries];
    logic [7:0]           rx_q [$];          // words seen with rx_valid
    logic [31:0]          rng = 32'd17257;
    int                   cyc = 0;
    int                   errors = 0;
    int                   passed = 0;
    int                   failed = 0;

    assign uart_in = bang ? bang_bit : uart_out;   // loopback by default

    uart_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("run stopped after %0d cycles, the tests did not finish", cyc);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge clk)
        if (!rst && rx_valid)
            rx_q.push_back(rx_data);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // odd mode needs an odd total of ones, even mode an even total
    function automatic logic parity_bit(input parity_t mode, input logic [7:0] d);
        logic ones_even;
        ones_even = ($countones(d) % 2) == 0;
        if (mode == parity_odd)
            return ones_even;
        return !ones_even;
    endfunction

    function automatic int frame_bits(input parity_t mode);
        return (mode == parity_odd || mode == parity_even) ? 11 : 10;
    endfunction

    function automatic logic frame_bit(input parity_t mode, input logic [7:0] d,
                                       input int k, input inj_t inj);
        if (k == 0)
            return 1'b0;                 // start
        if (k <= 8)
            return d[3'(k - 1)];         // LSB first
        if (k == 9 && frame_bits(mode) == 11)
            return parity_bit(mode, d) ^ (inj == inj_flip_parity);
        return inj != inj_stop_low;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic host_access(input logic we, input reg_addr_t addr, input logic [7:0] wdata,
                               output logic [7:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        do begin
            @(negedge clk);
            n++;
        end while (!host_ack && n < 8);
        if (!host_ack) begin
            $display("host_ack never rose for address %0d", addr);
            errors++;
        end
        rdata    = host_rdata;
        host_req = 1'b0;
        while (host_ack && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (host_ack) begin
            $display("host_ack stuck high after request dropped");
            errors++;
        end
    endtask

    task automatic read_check(input string name, input reg_addr_t addr, input logic [7:0] exp);
        logic [7:0] rd;
        host_access(1'b0, addr, 8'h00, rd);
        compare(name, 32'(rd), 32'(exp));
    endtask

    // sends one word and samples uart_out in the middle of each bit
    task automatic send_word(input parity_t mode, input logic [7:0] d);
        @(negedge clk);
        tx_data  = d;
        tx_valid = 1'b1;
        while (!tx_ready)
            @(negedge clk);
        @(negedge clk);          // accepted on the edge just passed
        tx_valid = 1'b0;
        for (int k = 0; k < frame_bits(mode); k++) begin
            repeat (k == 0 ? clks_per_bit / 2 : clks_per_bit) @(negedge clk);
            compare($sformatf("uart_out bit %0d", k), 32'(uart_out),
                    32'(frame_bit(mode, d, k, inj_none)));
        end
    endtask

    task automatic bang_frame(input parity_t mode, input logic [7:0] d, input inj_t inj);
        @(negedge clk);
        bang_bit = 1'b1;
        bang     = 1'b1;
        for (int k = 0; k < frame_bits(mode); k++) begin
            bang_bit = frame_bit(mode, d, k, inj);
            repeat (clks_per_bit) @(negedge clk);
        end
        bang_bit = 1'b1;         // one idle bit before handing back the line
        repeat (clks_per_bit) @(negedge clk);
        bang = 1'b0;
    endtask

    task automatic wait_rx(input int n, input int limit);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (rx_q.size() < n) begin
            $display("only %0d of %0d words arrived within %0d cycles", rx_q.size(), n, limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %-34s ok", name);
            passed++;
        end else begin
            $display("test %-34s FAILED with %0d errors", name, errors - errs_before);
            failed++;
        end
    endtask

    initial begin
        entry_t     e;
        logic [7:0] d;
        logic [7:0] rd;
        reg_addr_t  cnt_addr;
        int         errs_before;
        int         t0;

        rst        = 1'b1;
        tx_data    = '0;
        tx_valid   = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = addr_ctrl;
        host_wdata = 8'h00;
        bang       = 1'b0;
        bang_bit   = 1'b1;

        tests[0] = '{parity_none, 8'h55, 1'b0, inj_none, exp_ok};
        tests[1] = '{parity_odd, 8'ha3, 1'b0, inj_none, exp_ok};
        tests[2] = '{parity_even, 8'h00, 1'b1, inj_none, exp_ok};
        tests[3] = '{parity_odd, 8'h00, 1'b1, inj_none, exp_ok};
        tests[4] = '{parity_even, 8'hff, 1'b0, inj_none, exp_ok};
        tests[5] = '{parity_t'(2'd3), 8'h00, 1'b1, inj_none, exp_ok};   // 3 acts as none
        tests[6] = '{parity_odd, 8'h3c, 1'b0, inj_flip_parity, exp_perr};
        tests[7] = '{parity_even, 8'h00, 1'b1, inj_flip_parity, exp_perr};
        tests[8] = '{parity_none, 8'h81, 1'b0, inj_stop_low, exp_ferr};
        tests[9] = '{parity_even, 8'h5a, 1'b0, inj_stop_low, exp_ferr};

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs_before = errors;
        compare("uart_out", 32'(uart_out), 32'd1);
        compare("tx_ready", 32'(tx_ready), 32'd1);
        compare("rx_valid", 32'(rx_valid), 32'd0);
        compare("host_ack", 32'(host_ack), 32'd0);
        read_check("ctrl", addr_ctrl, 8'h00);
        read_check("perr_cnt", addr_perr_cnt, 8'h00);
        read_check("ferr_cnt", addr_ferr_cnt, 8'h00);
        report_test("after reset", errs_before);

        foreach (tests[i]) begin
            e = tests[i];
            if (e.rnd) begin
                rng = xorshift(rng);
                d   = rng[7:0];
            end else begin
                d = e.data;
            end
            errs_before = errors;
            rx_q.delete();
            host_access(1'b1, addr_ctrl, {6'd0, e.mode}, rd);
            read_check("ctrl", addr_ctrl, {6'd0, e.mode});
            if (e.inj == inj_none)
                send_word(e.mode, d);
            else
                bang_frame(e.mode, d, e.inj);
            if (e.exp == exp_ok) begin
                wait_rx(1, 4 * clks_per_bit);
                if (rx_q.size() > 0)
                    compare("rx_data", 32'(rx_q.pop_front()), 32'(d));
            end else begin
                repeat (clks_per_bit) @(negedge clk);
                compare("rx_valid count", 32'(rx_q.size()), 32'd0);
            end
            read_check("perr_cnt", addr_perr_cnt, (e.exp == exp_perr) ? 8'd1 : 8'd0);
            read_check("ferr_cnt", addr_ferr_cnt, (e.exp == exp_ferr) ? 8'd1 : 8'd0);
            if (e.exp != exp_ok) begin
                cnt_addr = (e.exp == exp_perr) ? addr_perr_cnt : addr_ferr_cnt;
                host_access(1'b1, cnt_addr, 8'ha5, rd);   // any value clears
                read_check("cleared counter", cnt_addr, 8'd0);
            end
            report_test($sformatf("%0d mode %0d data %h inj %0d", i + 1, e.mode, d, e.inj),
                        errs_before);
        end

        // second word waits behind the first, mode change lands between them
        errs_before = errors;
        rx_q.delete();
        host_access(1'b1, addr_ctrl, {6'd0, parity_none}, rd);
        @(negedge clk);
        tx_data  = 8'hc4;
        tx_valid = 1'b1;
        while (!tx_ready)
            @(negedge clk);
        @(negedge clk);
        t0      = cyc;
        tx_data = 8'h3b;
        repeat (4 * clks_per_bit) @(negedge clk);
        host_access(1'b1, addr_ctrl, {6'd0, parity_even}, rd);
        while (!tx_ready)
            @(negedge clk);
        compare("tx_ready low cycles", 32'(cyc - t0), 32'(10 * clks_per_bit));
        @(negedge clk);
        t0       = cyc;
        tx_valid = 1'b0;
        while (!tx_ready)
            @(negedge clk);
        compare("tx_ready low cycles", 32'(cyc - t0), 32'(11 * clks_per_bit));  // parity on
        wait_rx(2, 4 * clks_per_bit);
        if (rx_q.size() == 2) begin
            compare("rx_data first", 32'(rx_q.pop_front()), 32'h000000c4);
            compare("rx_data second", 32'(rx_q.pop_front()), 32'h0000003b);
        end
        read_check("perr_cnt", addr_perr_cnt, 8'd0);
        read_check("ferr_cnt", addr_ferr_cnt, 8'd0);
        report_test("back-pressure and mode change", errs_before);

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- uart_core.f
common/uart_pkg.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_core.sv
testbench/uart_core_assert.sv
testbench/tb_uart_core.sv

//--- Makefile
# Verilator flow for the UART core

VERILATOR ?= verilator
TOP       ?= tb_uart_core
FILELIST  ?= uart_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
